//--- hdl/video_pkg.sv
package video_pkg;

    // Pooled column index width, enough for FRAME_W up to 512
    localparam int COL_W = 8;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Wire order of the DVP and DBI byte streams
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } pixel_bytes_t;

    typedef union packed {
        rgb565_t      rgb;      // Per-channel view for pooling
        pixel_bytes_t bytes;    // Byte view for capture and display
    } pixel_u;

    typedef struct packed {
        logic             valid;
        pixel_u           pixel;
        logic             odd_col;
        logic             odd_row;
        logic [COL_W-1:0] col;  // Pooled column
    } cam_pixel_t;

    typedef struct packed {
        logic frame_start;
    } frame_sync_t;

endpackage

//--- hdl/panel_pkg.sv
package panel_pkg;

    localparam int CFG_ADDR_W = 4;

    // DCS memory write
    localparam logic [7:0] CMD_MEM_WRITE = 8'h2C;

    localparam logic [CFG_ADDR_W-1:0] REG_CTRL_ADDR = 4'h0;

    // Control register, bit 2 down to bit 0
    typedef struct packed {
        logic stream_en;
        logic cam_pwdn;
        logic panel_run;    // Drives panel RESX
    } ctrl_reg_t;

    // DBI type C write side, strobes active low
    typedef struct packed {
        logic       csx;
        logic       dcx;    // 0 command, 1 data
        logic       wrx;
        logic [7:0] d;
    } dbi_bus_t;

endpackage

//--- hdl/cfg_regs.sv
`timescale 1ns/100ps

module cfg_regs (
    input  logic                             sys_clk,
    input  logic                             rst_i,
    input  logic                             cfg_we_i,
    input  logic [panel_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [31:0]                      cfg_wdata_i,
    output logic [31:0]                      cfg_rdata_o,
    output panel_pkg::ctrl_reg_t             ctrl_o
);
    localparam int CTRL_W = $bits(panel_pkg::ctrl_reg_t);

    logic ctrl_sel;

    assign ctrl_sel = (cfg_addr_i == panel_pkg::REG_CTRL_ADDR);

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            // Camera held in power-down, panel in reset
            ctrl_o <= '{stream_en: 1'b0, cam_pwdn: 1'b1, panel_run: 1'b0};
        end else if (cfg_we_i && ctrl_sel) begin
            ctrl_o <= panel_pkg::ctrl_reg_t'(cfg_wdata_i[CTRL_W-1:0]);
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        cfg_rdata_o = '0;
        if (ctrl_sel) begin
            cfg_rdata_o[CTRL_W-1:0] = ctrl_o;
        end
    end

endmodule

//--- hdl/dvp_capture.sv
`timescale 1ns/100ps

module dvp_capture #(
    parameter int FRAME_W = 320
) (
    input  logic                     sys_clk,
    input  logic                     rst_i,
    input  logic                     stream_en_i,
    input  logic [7:0]               dvp_d_i,
    input  logic                     dvp_href_i,
    input  logic                     dvp_vsync_i,
    output video_pkg::cam_pixel_t    pixel_o,
    output video_pkg::frame_sync_t   sync_o
);
    localparam int PIX_W = $clog2(FRAME_W);
    localparam int COL_W = video_pkg::COL_W;

    logic             href_q;
    logic             vsync_q;
    logic             frame_en;     // Frame accepted at its vsync
    logic             byte_ph;      // High when the next byte is the low byte
    logic [7:0]       hi_q;
    logic [PIX_W-1:0] pix_col;
    logic             odd_row;
    logic             vsync_rise;
    logic             href_fall;
    logic             take;

    assign vsync_rise = dvp_vsync_i && !vsync_q;
    assign href_fall  = href_q && !dvp_href_i;
    assign take       = dvp_href_i && frame_en && stream_en_i;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            href_q             <= 1'b0;
            vsync_q            <= 1'b0;
            frame_en           <= 1'b0;
            byte_ph            <= 1'b0;
            pix_col            <= '0;
            odd_row            <= 1'b0;
            sync_o.frame_start <= 1'b0;
            pixel_o.valid      <= 1'b0;
        end else begin
            href_q             <= dvp_href_i;
            vsync_q            <= dvp_vsync_i;
            sync_o.frame_start <= vsync_rise && stream_en_i;
            pixel_o.valid      <= take && byte_ph;
            if (vsync_rise) begin
                frame_en <= stream_en_i;    // Only whole frames go downstream
                byte_ph  <= 1'b0;
                pix_col  <= '0;
                odd_row  <= 1'b0;
            end else if (href_fall) begin
                byte_ph  <= 1'b0;
                pix_col  <= '0;
                odd_row  <= !odd_row;
            end else if (take) begin
                byte_ph <= !byte_ph;
                if (byte_ph) begin
                    pix_col <= pix_col + 1'b1;
                end
            end
        end

        if (take && !byte_ph) begin
            hi_q <= dvp_d_i;
        end
        if (take && byte_ph) begin
            pixel_o.pixel.bytes.hi <= hi_q;
            pixel_o.pixel.bytes.lo <= dvp_d_i;
            pixel_o.odd_col        <= pix_col[0];
            pixel_o.odd_row        <= odd_row;
            pixel_o.col            <= COL_W'(pix_col >> 1);
        end
    end

endmodule

//--- hdl/max_pool_2x2.sv
`timescale 1ns/100ps

module max_pool_2x2 #(
    parameter int FRAME_W = 320
) (
    input  logic                    sys_clk,
    input  logic                    rst_i,
    input  video_pkg::cam_pixel_t   pixel_i,
    output logic                    pool_valid_o,
    output video_pkg::pixel_u       pool_pixel_o
);
    localparam int BUF_DEPTH = FRAME_W / 2;
    localparam int BUF_AW    = $clog2(BUF_DEPTH);

    video_pkg::pixel_u  even_q;
    video_pkg::pixel_u  pair_max;
    video_pkg::pixel_u  line_rd;
    video_pkg::pixel_u  line_buf [BUF_DEPTH];
    logic [BUF_AW-1:0]  buf_idx;
    logic               odd_hit;

    function automatic video_pkg::pixel_u max_rgb(
        input video_pkg::pixel_u a,
        input video_pkg::pixel_u b
    );
        video_pkg::pixel_u m;
        m.rgb.red   = (a.rgb.red   > b.rgb.red)   ? a.rgb.red   : b.rgb.red;
        m.rgb.green = (a.rgb.green > b.rgb.green) ? a.rgb.green : b.rgb.green;
        m.rgb.blue  = (a.rgb.blue  > b.rgb.blue)  ? a.rgb.blue  : b.rgb.blue;
        return m;
    endfunction

    assign buf_idx  = pixel_i.col[BUF_AW-1:0];
    assign odd_hit  = pixel_i.valid && pixel_i.odd_col;
    assign pair_max = max_rgb(even_q, pixel_i.pixel);   // Horizontal pair
    assign line_rd  = line_buf[buf_idx];

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            pool_valid_o <= 1'b0;
        end else begin
            pool_valid_o <= odd_hit && pixel_i.odd_row;
        end

        if (pixel_i.valid && !pixel_i.odd_col) begin
            even_q <= pixel_i.pixel;
        end
        // Vertical max against the pair stored on the even row
        if (odd_hit && pixel_i.odd_row) begin
            pool_pixel_o <= max_rgb(line_rd, pair_max);
        end
    end

    // Half-line buffer of even-row pair maxima
    always_ff @(posedge sys_clk) begin
        if (odd_hit && !pixel_i.odd_row) begin
            line_buf[buf_idx] <= pair_max;
        end
    end

endmodule

//--- hdl/pixel_fifo.sv
`timescale 1ns/100ps

module pixel_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                sys_clk,
    input  logic                rst_i,
    input  logic                push_i,
    input  video_pkg::pixel_u   data_i,
    input  logic                pop_i,
    output video_pkg::pixel_u   data_o,
    output logic                empty_o,
    output logic                full_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    video_pkg::pixel_u mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              do_push;
    logic              do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem[rd_ptr];   // Show-ahead

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- hdl/dbi_writer.sv
`timescale 1ns/100ps

module dbi_writer #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    sys_clk,
    input  logic                    rst_i,
    input  video_pkg::frame_sync_t  sync_i,
    input  logic                    pool_valid_i,
    input  video_pkg::pixel_u       pool_pixel_i,
    output panel_pkg::dbi_bus_t     dbi_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WR_LOW,
        ST_WR_HIGH
    } state_t;

    state_t            state;
    logic              cmd_pending;
    logic              lo_pending;     // Low byte of the current pixel still due
    logic [7:0]        lo_byte;
    logic              fifo_push;
    logic              fifo_empty;
    logic              fifo_full;
    video_pkg::pixel_u fifo_rd;
    logic              can_issue;
    logic              issue_lo;
    logic              issue_pix;
    logic              issue_cmd;

    assign fifo_push = pool_valid_i && !fifo_full;

    pixel_fifo #(
        .DEPTH      (FIFO_DEPTH)
    ) i_pixel_fifo (
        .sys_clk    (sys_clk),
        .rst_i      (rst_i),
        .push_i     (fifo_push),
        .data_i     (pool_pixel_i),
        .pop_i      (issue_pix),
        .data_o     (fifo_rd),
        .empty_o    (fifo_empty),
        .full_o     (fifo_full)
    );

    // A new byte may start while idle or in the wrx high half of a byte
    assign can_issue = (state == ST_IDLE) || (state == ST_WR_HIGH);
    assign issue_lo  = can_issue && lo_pending;
    assign issue_pix = can_issue && !lo_pending && !fifo_empty;
    // Pixels already queued belong to the previous frame
    assign issue_cmd = can_issue && !lo_pending && fifo_empty && cmd_pending;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state       <= ST_IDLE;
            cmd_pending <= 1'b0;
            lo_pending  <= 1'b0;
            dbi_o       <= '{csx: 1'b1, dcx: 1'b1, wrx: 1'b1, d: 8'h00};
        end else begin
            if (sync_i.frame_start) begin
                cmd_pending <= 1'b1;
            end else if (issue_cmd) begin
                cmd_pending <= 1'b0;
            end

            case (state)
                ST_WR_LOW: begin
                    dbi_o.wrx <= 1'b1;  // Panel latches on this edge
                    state     <= ST_WR_HIGH;
                end
                default: begin
                    if (issue_lo) begin
                        dbi_o.d    <= lo_byte;
                        dbi_o.wrx  <= 1'b0;
                        lo_pending <= 1'b0;
                        state      <= ST_WR_LOW;
                    end else if (issue_pix) begin
                        dbi_o.d    <= fifo_rd.bytes.hi;
                        dbi_o.dcx  <= 1'b1;
                        dbi_o.wrx  <= 1'b0;
                        dbi_o.csx  <= 1'b0;
                        lo_pending <= 1'b1;
                        state      <= ST_WR_LOW;
                    end else if (issue_cmd) begin
                        dbi_o.d   <= panel_pkg::CMD_MEM_WRITE;
                        dbi_o.dcx <= 1'b0;
                        dbi_o.wrx <= 1'b0;
                        dbi_o.csx <= 1'b0;
                        state     <= ST_WR_LOW;
                    end else begin
                        dbi_o.csx <= 1'b1;  // Burst done
                        state     <= ST_IDLE;
                    end
                end
            endcase
        end

        if (issue_pix) begin
            lo_byte <= fifo_rd.bytes.lo;
        end
    end

endmodule

//--- hdl/dcasic_video.sv
`timescale 1ns/100ps

module dcasic_video #(
    parameter int FRAME_W    = 320,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             sys_clk,
    input  logic                             rst_i,
    // Camera
    input  logic [7:0]                       dvp_d_i,
    input  logic                             dvp_href_i,
    input  logic                             dvp_vsync_i,
    output logic                             dvp_pwdn_o,
    // Configuration
    input  logic                             cfg_we_i,
    input  logic [panel_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [31:0]                      cfg_wdata_i,
    output logic [31:0]                      cfg_rdata_o,
    // Display
    output logic                             dbi_csx_o,
    output logic                             dbi_dcx_o,
    output logic                             dbi_wrx_o,
    output logic                             dbi_resx_o,
    output logic [7:0]                       dbi_d_o
);
    panel_pkg::ctrl_reg_t   ctrl;
    video_pkg::cam_pixel_t  cam_pixel;
    video_pkg::frame_sync_t frame_sync;
    logic                   pool_valid;
    video_pkg::pixel_u      pool_pixel;
    panel_pkg::dbi_bus_t    dbi;

    cfg_regs i_cfg_regs (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .ctrl_o         (ctrl)
    );

    dvp_capture #(
        .FRAME_W        (FRAME_W)
    ) i_dvp_capture (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .stream_en_i    (ctrl.stream_en),
        .dvp_d_i        (dvp_d_i),
        .dvp_href_i     (dvp_href_i),
        .dvp_vsync_i    (dvp_vsync_i),
        .pixel_o        (cam_pixel),
        .sync_o         (frame_sync)
    );

    max_pool_2x2 #(
        .FRAME_W        (FRAME_W)
    ) i_max_pool_2x2 (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .pixel_i        (cam_pixel),
        .pool_valid_o   (pool_valid),
        .pool_pixel_o   (pool_pixel)
    );

    dbi_writer #(
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) i_dbi_writer (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .sync_i         (frame_sync),
        .pool_valid_i   (pool_valid),
        .pool_pixel_i   (pool_pixel),
        .dbi_o          (dbi)
    );

    assign dvp_pwdn_o = ctrl.cam_pwdn;
    assign dbi_resx_o = ctrl.panel_run;     // RESX is active low
    assign dbi_csx_o  = dbi.csx;
    assign dbi_dcx_o  = dbi.dcx;
    assign dbi_wrx_o  = dbi.wrx;
    assign dbi_d_o    = dbi.d;

endmodule

//--- testbench/dcasic_video_chk.sv
`timescale 1ns/100ps

module dcasic_video_chk (
    input  logic                sys_clk,
    input  logic                rst_i,
    input  panel_pkg::dbi_bus_t dbi_i,
    input  logic                push_req_i,
    input  logic                fifo_full_i
);

    // Every byte has one low and one high cycle
    property wrx_single_low;
        @(posedge sys_clk) disable iff (rst_i)
        !dbi_i.wrx |=> dbi_i.wrx;
    endproperty

    property csx_covers_wrx;
        @(posedge sys_clk) disable iff (rst_i)
        !dbi_i.wrx |-> !dbi_i.csx;
    endproperty

    property no_push_when_full;
        @(posedge sys_clk) disable iff (rst_i)
        push_req_i |-> !fifo_full_i;
    endproperty

    assert property (wrx_single_low) else $error("wrx low for two cycles");
    assert property (csx_covers_wrx) else $error("wrx low while csx high");
    assert property (no_push_when_full) else $error("Pixel pushed into a full FIFO");

endmodule

bind dbi_writer dcasic_video_chk i_dcasic_video_chk (
    .sys_clk        (sys_clk),
    .rst_i          (rst_i),
    .dbi_i          (dbi_o),
    .push_req_i     (pool_valid_i),
    .fifo_full_i    (fifo_full)
);

//--- testbench/tb_dcasic_video.sv
`timescale 1ns/100ps

module tb_dcasic_video;

    localparam int FRAME_W        = 16;
    localparam int FIFO_DEPTH     = 4;
    localparam int ROWS           = 4;
    localparam int N_FRAMES       = 7;
    localparam int GAP_MAX        = 12;
    localparam int DRAIN_MAX      = 100;
    localparam int TIMEOUT_CYCLES = N_FRAMES * ROWS * (2 * FRAME_W + GAP_MAX) * 2 + 200;
    localparam logic [31:0] SEED  = 32'h5197;
    localparam logic [7:0]  CMD_MEM_WRITE = 8'h2C;
    localparam logic [3:0]  CTRL_ADDR     = 4'h0;

    logic        sys_clk = 1'b0;
    logic        rst_i;
    logic [7:0]  dvp_d_i;
    logic        dvp_href_i;
    logic        dvp_vsync_i;
    logic        dvp_pwdn_o;
    logic        cfg_we_i;
    logic [3:0]  cfg_addr_i;
    logic [31:0] cfg_wdata_i;
    logic [31:0] cfg_rdata_o;
    logic        dbi_csx_o;
    logic        dbi_dcx_o;
    logic        dbi_wrx_o;
    logic        dbi_resx_o;
    logic [7:0]  dbi_d_o;

    logic [15:0] frame_pix [ROWS][FRAME_W];
    logic [8:0]  exp_q [$];             // {dcx, d} in output order
    int          cycle_cnt = 0;
    int          byte_cnt = 0;
    logic        wrx_prev = 1'b1;

    dcasic_video #(
        .FRAME_W        (FRAME_W),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) i_dcasic_video (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .dvp_d_i        (dvp_d_i),
        .dvp_href_i     (dvp_href_i),
        .dvp_vsync_i    (dvp_vsync_i),
        .dvp_pwdn_o     (dvp_pwdn_o),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i),
        .cfg_rdata_o    (cfg_rdata_o),
        .dbi_csx_o      (dbi_csx_o),
        .dbi_dcx_o      (dbi_dcx_o),
        .dbi_wrx_o      (dbi_wrx_o),
        .dbi_resx_o     (dbi_resx_o),
        .dbi_d_o        (dbi_d_o)
    );

    always #20 sys_clk = ~sys_clk;

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s: got 'h%0h, expected 'h%0h",
                     $time, what, actual, expected);
            stop_on_error();
        end
    endtask

    // Per-channel max of one 2x2 block
    function automatic logic [15:0] pooled_pixel(input int prow, input int pcol);
        logic [4:0]  red;
        logic [5:0]  green;
        logic [4:0]  blue;
        logic [15:0] p;
        red   = '0;
        green = '0;
        blue  = '0;
        for (int dr = 0; dr < 2; dr++) begin
            for (int dc = 0; dc < 2; dc++) begin
                p = frame_pix[2 * prow + dr][2 * pcol + dc];
                if (p[15:11] > red)   red   = p[15:11];
                if (p[10:5]  > green) green = p[10:5];
                if (p[4:0]   > blue)  blue  = p[4:0];
            end
        end
        return {red, green, blue};
    endfunction

    task automatic queue_expected_bytes();
        logic [15:0] pix;
        exp_q.push_back({1'b0, CMD_MEM_WRITE});
        for (int pr = 0; pr < ROWS / 2; pr++) begin
            for (int pc = 0; pc < FRAME_W / 2; pc++) begin
                pix = pooled_pixel(pr, pc);
                exp_q.push_back({1'b1, pix[15:8]});     // High byte first
                exp_q.push_back({1'b1, pix[7:0]});
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge sys_clk);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge sys_clk);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge sys_clk);
        cfg_we_i    = 1'b0;
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] value);
        @(negedge sys_clk);
        cfg_addr_i = addr;
        #1;
        check_value($sformatf("readback at %0h", addr), cfg_rdata_o, value);
    endtask

    // One frame of random bytes, expected output queued only when streaming
    task automatic send_frame(input bit expect_out);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                frame_pix[r][c] = 16'($urandom);
            end
        end
        if (expect_out) begin
            queue_expected_bytes();
        end
        idle_cycles($urandom_range(GAP_MAX, 1));
        dvp_vsync_i = 1'b1;
        idle_cycles(3);
        dvp_vsync_i = 1'b0;
        idle_cycles($urandom_range(GAP_MAX, 1));
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                @(negedge sys_clk);
                dvp_href_i = 1'b1;
                dvp_d_i    = frame_pix[r][c][15:8];
                @(negedge sys_clk);
                dvp_d_i    = frame_pix[r][c][7:0];
            end
            @(negedge sys_clk);
            dvp_href_i = 1'b0;
            dvp_d_i    = 8'h00;
            idle_cycles($urandom_range(GAP_MAX, 1) - 1);
        end
    endtask

    // Byte monitor, one compare per completed wrx pulse
    always @(negedge sys_clk) begin : byte_monitor
        logic rose;
        rose     = (wrx_prev === 1'b0) && (dbi_wrx_o === 1'b1);
        wrx_prev = dbi_wrx_o;
        if (rose) begin
            if (exp_q.size() == 0) begin
                $display("Display byte %h written while no byte was expected", dbi_d_o);
                stop_on_error();
            end else begin
                byte_cnt++;
                check_value($sformatf("display byte %0d", byte_cnt),
                            {23'd0, dbi_dcx_o, dbi_d_o}, {23'd0, exp_q.pop_front()});
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, display output never completed", cycle_cnt);
            stop_on_error();
        end
    end

    initial begin
        int drain;
        void'($urandom(SEED));
        rst_i       = 1'b1;
        dvp_d_i     = 8'h00;
        dvp_href_i  = 1'b0;
        dvp_vsync_i = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = 4'h0;
        cfg_wdata_i = 32'h0;
        repeat (2) @(negedge sys_clk);
        rst_i = 1'b0;

        check_value("csx after reset", dbi_csx_o, 1);
        check_value("dcx after reset", dbi_dcx_o, 1);
        check_value("wrx after reset", dbi_wrx_o, 1);
        check_value("resx after reset", dbi_resx_o, 0);
        check_value("pwdn after reset", dvp_pwdn_o, 1);
        expect_reg(CTRL_ADDR, 32'h2);

        write_reg(CTRL_ADDR, 32'h3);    // pwdn and panel run
        expect_reg(CTRL_ADDR, 32'h3);
        expect_reg(4'h5, 32'h0);        // Unmapped while the register is set
        check_value("pwdn pin", dvp_pwdn_o, 1);
        check_value("resx pin", dbi_resx_o, 1);
        write_reg(CTRL_ADDR, 32'h0);
        check_value("pwdn pin", dvp_pwdn_o, 0);
        check_value("resx pin", dbi_resx_o, 0);
        write_reg(4'h5, 32'h7);         // Unmapped, ignored
        expect_reg(CTRL_ADDR, 32'h0);
        expect_reg(4'h5, 32'h0);

        // Camera activity with streaming off
        send_frame(1'b0);
        check_value("csx with stream off", dbi_csx_o, 1);

        write_reg(CTRL_ADDR, 32'h5);
        expect_reg(CTRL_ADDR, 32'h5);
        check_value("pwdn pin", dvp_pwdn_o, 0);
        check_value("resx pin", dbi_resx_o, 1);
        repeat (3) send_frame(1'b1);

        write_reg(CTRL_ADDR, 32'h1);
        send_frame(1'b0);
        write_reg(CTRL_ADDR, 32'h5);
        repeat (2) send_frame(1'b1);

        drain = 0;
        while (drain < DRAIN_MAX && (exp_q.size() != 0 || dbi_csx_o !== 1'b1)) begin
            @(negedge sys_clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("Run ended with %0d display bytes never written", exp_q.size());
            stop_on_error();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- filelist.f
hdl/video_pkg.sv
hdl/panel_pkg.sv
hdl/cfg_regs.sv
hdl/dvp_capture.sv
hdl/max_pool_2x2.sv
hdl/pixel_fifo.sv
hdl/dbi_writer.sv
hdl/dcasic_video.sv
testbench/dcasic_video_chk.sv
testbench/tb_dcasic_video.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dcasic_video
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
